/* include/tile_macros.svh */
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Tile geometry.
`define TILE_SIDES 4
`define TILE_TRACKS 4

// Configuration bus widths.
`define CFG_ADDR_W 32
`define CFG_DATA_W 32
`define TILE_ID_W 16 // Low half of the address.
`define CFG_SEL_W 3 // Operand select, eight tracks.
`define CFG_OP_W 2

// Block codes carried in the high half of the address.
`define CFG_BLOCK_SB 16'd7
`define CFG_BLOCK_CB0 16'd6
`define CFG_BLOCK_CB1 16'd5
`define CFG_BLOCK_CLB 16'd4

`endif

/* run.sh */
#!/bin/sh

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module pe_tile_tb -o pe_tile_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/pe_tile_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

/* src/logic_block.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module logic_block (
	input logic clk,
	input logic reset,
	input tile_pkg::track_bus_t tracks_in,
	input tile_pkg::track_bus_t tracks_out,
	input logic [`CFG_SEL_W-1:0] cb0_sel,
	input logic [`CFG_SEL_W-1:0] cb1_sel,
	input tile_pkg::logic_op_t op,
	output logic pe_out
);
	import tile_pkg::*;

	localparam int CB_TRACKS = 2 * `TILE_TRACKS;

	logic [CB_TRACKS-1:0] cb0_tracks;
	logic [CB_TRACKS-1:0] cb1_tracks;
	logic op0;
	logic op1;
	logic result;

	// Eight candidate tracks of one side, incoming first.
	function automatic logic pick_track(
		input logic [CB_TRACKS-1:0] cand,
		input logic [`CFG_SEL_W-1:0] sel
	);
		logic bit_out;
		bit_out = cand[sel];
		return bit_out;
	endfunction

	// Indices 4..7 are the tile's own outgoing tracks.
	assign cb0_tracks = {tracks_out.side_0, tracks_in.side_0};
	assign cb1_tracks = {tracks_out.side_1, tracks_in.side_1};

	assign op0 = pick_track(cb0_tracks, cb0_sel);
	assign op1 = pick_track(cb1_tracks, cb1_sel);

	always_comb begin
		case (op)
			OP_AND: begin
				result = op0 & op1;
			end
			OP_OR: begin
				result = op0 | op1;
			end
			OP_XOR: begin
				result = op0 ^ op1;
			end
			OP_NAND: begin
				result = ~(op0 & op1);
			end
			default: begin
				result = 1'bx;
			end
		endcase
	end

	// Breaks the loop through the switch box.
	always_ff @(posedge clk) begin
		if (reset) begin
			pe_out <= 1'b0;
		end else begin
			pe_out <= result;
		end
	end

	a_reset_clear: assert property (@(posedge clk) reset |=> !pe_out)
		else $error("logic_block: pe_out not cleared after reset");

endmodule

/* src/pe_tile.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module pe_tile (
	input logic clk,
	input logic reset,
	input logic [`CFG_ADDR_W-1:0] config_addr,
	input logic [`CFG_DATA_W-1:0] config_data,
	input logic [`TILE_ID_W-1:0] tile_id,
	input tile_pkg::track_bus_t tracks_in,
	output tile_pkg::track_bus_t tracks_out
);
	import tile_pkg::*;

	tile_cfg_t cfg;
	logic pe_out;

	tile_config u_config (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(tile_id),
		.cfg(cfg)
	);

	switch_box u_sb (
		.tracks_in(tracks_in),
		.pe_out(pe_out),
		.sb_cfg(cfg.sb),
		.tracks_out(tracks_out)
	);

	// Operands also tap the outgoing tracks.
	logic_block u_clb (
		.clk(clk),
		.reset(reset),
		.tracks_in(tracks_in),
		.tracks_out(tracks_out),
		.cb0_sel(cfg.cb0_sel),
		.cb1_sel(cfg.cb1_sel),
		.op(cfg.op),
		.pe_out(pe_out)
	);

endmodule

/* src/switch_box.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module switch_box (
	input tile_pkg::track_bus_t tracks_in,
	input logic pe_out,
	input tile_pkg::sb_cfg_t sb_cfg,
	output tile_pkg::track_bus_t tracks_out
);
	import tile_pkg::*;

	localparam int SIDES = `TILE_SIDES;
	localparam int TRACKS = `TILE_TRACKS;
	localparam int N_OUT = SIDES * TRACKS;

	logic [N_OUT-1:0] in_flat;
	logic [N_OUT-1:0] out_flat;

	assign in_flat = tracks_in; // Bit s*4+t is track t of side s.

	for (genvar s = 0; s < SIDES; s++) begin : g_side
		for (genvar t = 0; t < TRACKS; t++) begin : g_track
			localparam int IDX = s * TRACKS + t;
			// Same track on each of the other three sides.
			localparam int SRC_NEXT = ((s + 1) % SIDES) * TRACKS + t;
			localparam int SRC_OPP = ((s + 2) % SIDES) * TRACKS + t;
			localparam int SRC_PREV = ((s + 3) % SIDES) * TRACKS + t;

			route_sel_t sel;

			assign sel = sb_cfg[IDX];

			always_comb begin
				case (sel)
					ROUTE_NEXT: begin
						out_flat[IDX] = in_flat[SRC_NEXT];
					end
					ROUTE_OPPOSITE: begin
						out_flat[IDX] = in_flat[SRC_OPP];
					end
					ROUTE_PREV: begin
						out_flat[IDX] = in_flat[SRC_PREV];
					end
					ROUTE_PE: begin
						out_flat[IDX] = pe_out; // Registered, so no loop.
					end
					default: begin
						out_flat[IDX] = 1'bx;
					end
				endcase
			end
		end
	end

	assign tracks_out = out_flat;

	// Checked once the inputs have settled.
	always_comb begin
		if (!$isunknown({tracks_in, pe_out, sb_cfg})) begin
			a_out_known: assert final (!$isunknown(tracks_out))
				else $error("switch_box: unknown output with known inputs");
		end
	end

endmodule

/* src/tile_config.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module tile_config (
	input logic clk,
	input logic reset,
	input logic [`CFG_ADDR_W-1:0] config_addr,
	input logic [`CFG_DATA_W-1:0] config_data,
	input logic [`TILE_ID_W-1:0] tile_id,
	output tile_pkg::tile_cfg_t cfg
);
	import tile_pkg::*;

	logic [`TILE_ID_W-1:0] addr_id;
	logic [`CFG_ADDR_W-`TILE_ID_W-1:0] addr_block;
	logic id_match;
	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;

	sb_cfg_t sb_q;
	logic [`CFG_SEL_W-1:0] cb0_q;
	logic [`CFG_SEL_W-1:0] cb1_q;
	logic_op_t op_q;

	assign addr_id = config_addr[`TILE_ID_W-1:0];
	assign addr_block = config_addr[`CFG_ADDR_W-1:`TILE_ID_W];
	assign id_match = (addr_id == tile_id);

	// Level write, no strobe.
	assign en_sb = id_match && (addr_block == `CFG_BLOCK_SB);
	assign en_cb0 = id_match && (addr_block == `CFG_BLOCK_CB0);
	assign en_cb1 = id_match && (addr_block == `CFG_BLOCK_CB1);
	assign en_clb = id_match && (addr_block == `CFG_BLOCK_CLB);

	always_ff @(posedge clk) begin
		if (reset) begin
			sb_q <= '0; // Every route to side s+1.
		end else if (en_sb) begin
			sb_q <= sb_cfg_t'(config_data);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cb0_q <= '0;
			cb1_q <= '0;
		end else begin
			if (en_cb0) begin
				cb0_q <= config_data[`CFG_SEL_W-1:0];
			end
			if (en_cb1) begin
				cb1_q <= config_data[`CFG_SEL_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= OP_AND;
		end else if (en_clb) begin
			op_q <= logic_op_t'(config_data[`CFG_OP_W-1:0]);
		end
	end

	assign cfg.sb = sb_q;
	assign cfg.cb0_sel = cb0_q;
	assign cfg.cb1_sel = cb1_q;
	assign cfg.op = op_q;

	// One block per address.
	a_one_enable: assert property (@(posedge clk) disable iff (reset)
		$onehot0({en_sb, en_cb0, en_cb1, en_clb}))
		else $error("tile_config: more than one block enable active");

	a_op_defined: assert property (@(posedge clk) disable iff (reset)
		en_clb |=> !$isunknown(cfg.op))
		else $error("tile_config: logic block write stored an unknown operation");

endmodule

/* src/tile_pkg.sv */
`include "tile_macros.svh"

package tile_pkg;

	typedef logic [`TILE_TRACKS-1:0] side_t;

	// Side 0 sits in the low bits.
	typedef struct packed {
		side_t side_3;
		side_t side_2;
		side_t side_1;
		side_t side_0;
	} track_bus_t;

	// Route select per output track.
	typedef logic [1:0] route_sel_t;

	localparam route_sel_t ROUTE_NEXT = 2'd0; // Side s+1.
	localparam route_sel_t ROUTE_OPPOSITE = 2'd1; // Side s+2.
	localparam route_sel_t ROUTE_PREV = 2'd2; // Side s+3.
	localparam route_sel_t ROUTE_PE = 2'd3; // Compute output.

	// Element s*4+t steers output track t of side s.
	typedef route_sel_t [`TILE_SIDES*`TILE_TRACKS-1:0] sb_cfg_t;

	typedef enum logic [`CFG_OP_W-1:0] {
		OP_AND = 2'd0,
		OP_OR = 2'd1,
		OP_XOR = 2'd2,
		OP_NAND = 2'd3
	} logic_op_t;

	typedef struct packed {
		sb_cfg_t sb;
		logic [`CFG_SEL_W-1:0] cb0_sel;
		logic [`CFG_SEL_W-1:0] cb1_sel;
		logic_op_t op;
	} tile_cfg_t;

endpackage

/* verif/pe_tile_tb.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module pe_tile_tb;
	import tile_pkg::*;

	localparam int MAX_CYCLES = 1500; // Tests need about 1000.
	localparam logic [15:0] TILE_ID = 16'h002a;
	localparam logic [31:0] IDLE_ADDR = 32'hffff_ffff; // Matches no tile.

	logic clk;
	logic reset;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	track_bus_t tracks_in;
	track_bus_t tracks_out;

	sb_cfg_t sb_m; // Configuration mirror.
	logic [2:0] cb0_m;
	logic [2:0] cb1_m;
	logic [1:0] op_m;
	logic pe_m;
	track_bus_t exp_out;
	int cycle_count = 0;
	int fail_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int fails_at_start = 0;

	tb_clock u_clock (
		.clk(clk),
		.reset(reset)
	);

	pe_tile UUT (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(tile_id),
		.tracks_in(tracks_in),
		.tracks_out(tracks_out)
	);

	// Output s*4+t takes track t of side s+sel+1, or pe_out for select 3.
	function automatic track_bus_t route_tracks(track_bus_t tin, sb_cfg_t sb, logic pe);
		logic [15:0] src;
		logic [15:0] res;
		int side;
		src = tin;
		for (int i = 0; i < 16; i++) begin
			side = i / 4;
			if (sb[i] == 2'd3)
				res[i] = pe;
			else
				res[i] = src[((side + sb[i] + 1) % 4) * 4 + i % 4];
		end
		return res;
	endfunction

	function automatic logic pick_operand(logic [3:0] tin, logic [3:0] tout, logic [2:0] sel);
		if (sel < 3'd4)
			return tin[sel[1:0]];
		return tout[sel[1:0]]; // Own outgoing track.
	endfunction

	function automatic logic apply_op(logic [1:0] op, logic a, logic b);
		case (op)
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	function automatic track_bus_t random_tracks();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	assign exp_out = route_tracks(tracks_in, sb_m, pe_m);

	always @(posedge clk) begin
		if (reset) begin
			sb_m <= '0;
			cb0_m <= '0;
			cb1_m <= '0;
			op_m <= OP_AND;
			pe_m <= 1'b0;
		end else begin
			pe_m <= apply_op(op_m, pick_operand(tracks_in.side_0, exp_out.side_0, cb0_m),
				pick_operand(tracks_in.side_1, exp_out.side_1, cb1_m));
			if (config_addr[15:0] == tile_id) begin
				case (config_addr[31:16])
					`CFG_BLOCK_SB: sb_m <= config_data;
					`CFG_BLOCK_CB0: cb0_m <= config_data[2:0];
					`CFG_BLOCK_CB1: cb1_m <= config_data[2:0];
					`CFG_BLOCK_CLB: op_m <= config_data[1:0];
					default: ;
				endcase
			end
		end
	end

	a_tracks_match: assert property (@(posedge clk) disable iff (reset) tracks_out == exp_out)
		else begin
			$display("mismatch at %0t: tracks_out %h, expected %h", $time,
				$sampled(tracks_out), $sampled(exp_out));
			fail_count++;
		end

	a_pe_match: assert property (@(posedge clk) disable iff (reset) UUT.pe_out == pe_m)
		else begin
			$display("mismatch at %0t: pe_out %b, expected %b", $time,
				$sampled(UUT.pe_out), $sampled(pe_m));
			fail_count++;
		end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// One capturing edge before the address is parked.
	task automatic write_cfg(input logic [15:0] block, input logic [15:0] id,
		input logic [31:0] data);
		@(negedge clk);
		config_addr = {block, id};
		config_data = data;
		@(negedge clk);
		config_addr = IDLE_ADDR;
	endtask

	task automatic run_tracks(input int n);
		repeat (n) begin
			@(negedge clk);
			tracks_in = random_tracks();
		end
	endtask

	task automatic finish_test(input string name);
		@(negedge clk);
		if (fail_count == fails_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, fail_count - fails_at_start);
		end
		fails_at_start = fail_count;
	endtask

	initial begin
		logic [31:0] r;
		void'($urandom(62349));
		// Reset has priority over this write.
		config_addr = {`CFG_BLOCK_SB, TILE_ID};
		config_data = 32'hffff_ffff;
		tile_id = TILE_ID;
		tracks_in = '1; // Operands of one while pe_out is held clear.
		@(negedge reset);
		config_addr = IDLE_ADDR;
		config_data = '0;
		@(negedge clk);

		run_tracks(16); // Default routes.
		tracks_in = '0;
		write_cfg(`CFG_BLOCK_CLB, TILE_ID, 32'd0);
		write_cfg(`CFG_BLOCK_SB, TILE_ID, 32'hffff_ffff); // Every output from pe_out.
		repeat (4) @(negedge clk);
		finish_test("reset_defaults");

		repeat (40) begin
			r = $urandom();
			write_cfg(`CFG_BLOCK_SB, TILE_ID, r);
			run_tracks(4);
		end
		finish_test("routing");

		write_cfg(`CFG_BLOCK_SB, TILE_ID, 32'hffff_ffff);
		for (int k = 0; k < 4; k++) begin
			write_cfg(`CFG_BLOCK_CLB, TILE_ID, {30'd0, k[1:0]});
			repeat (10) begin
				r = $urandom();
				write_cfg(`CFG_BLOCK_CB0, TILE_ID, {29'd0, 1'b0, r[1:0]});
				write_cfg(`CFG_BLOCK_CB1, TILE_ID, {29'd0, 1'b0, r[3:2]});
				run_tracks(3);
			end
		end
		finish_test("logic_functions");

		repeat (30) begin
			r = $urandom();
			write_cfg(`CFG_BLOCK_SB, TILE_ID, r);
			r = $urandom();
			write_cfg(`CFG_BLOCK_CB0, TILE_ID, {29'd0, 1'b1, r[1:0]}); // Selects 4 to 7.
			write_cfg(`CFG_BLOCK_CB1, TILE_ID, {29'd0, 1'b1, r[3:2]});
			write_cfg(`CFG_BLOCK_CLB, TILE_ID, {30'd0, r[5:4]});
			run_tracks(3);
		end
		finish_test("operand_feedback");

		for (int k = 0; k < 12; k++) begin
			r = $urandom();
			write_cfg({14'd1, k[1:0]}, TILE_ID ^ (r[15:0] | 16'h0001), $urandom());
			run_tracks(2);
			// Unused codes below and above the block range.
			write_cfg(k[0] ? {r[31:19] | 13'h0001, r[18:16]} : {14'd0, r[17:16]},
				TILE_ID, $urandom());
			run_tracks(2);
			write_cfg({14'd1, k[1:0]}, TILE_ID, $urandom());
			run_tracks(2);
		end
		finish_test("address_filtering");

		$display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed,
			fail_count);
		if (tests_failed == 0 && fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	// Four rising edges in reset, released on a falling edge.
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* verilog.f */
+incdir+include
src/tile_pkg.sv
src/tile_config.sv
src/switch_box.sv
src/logic_block.sv
src/pe_tile.sv
verif/tb_clock.sv
verif/pe_tile_tb.sv
